/* bench/lb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module lb_mem_model (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Request side
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  lb_pkg::addr_t   req_addr_i,
  input  lb_pkg::lb_idx_t req_tag_i,
  // Response side
  output logic            resp_valid_o,
  output lb_pkg::lb_idx_t resp_tag_o,
  output lb_pkg::data_t   resp_rdata_o
);
  import lb_pkg::*;

  // Outputs start low so the DUT never sees X
  logic    ready_q = 1'b0;
  logic    valid_q = 1'b0;
  lb_idx_t tag_q   = '0;
  data_t   rdata_q = '0;

  // Outstanding requests, indexed by tag
  logic        pending [LB_DEPTH];
  int unsigned delay   [LB_DEPTH];
  addr_t       addr    [LB_DEPTH];

  // Byte at address a is a[7:0] xor 8'h5a
  function automatic data_t read_dword(addr_t a);
    data_t d;
    for (int i = 0; i < 8; i++) begin
      d[8*i +: 8] = 8'(a + addr_t'(i)) ^ 8'h5a;
    end
    return d;
  endfunction

  // All outputs move on the falling edge
  always @(negedge clk_i) begin
    int unsigned start;
    lb_idx_t     t;
    logic        found;
    if (!rst_ni) begin
      for (int i = 0; i < LB_DEPTH; i++) begin
        pending[i] = 1'b0;
        delay[i]   = 0;
      end
      ready_q = 1'b0;
      valid_q = 1'b0;
    end else begin
      for (int i = 0; i < LB_DEPTH; i++) begin
        if (pending[i] && delay[i] != 0) begin
          delay[i]--;
        end
      end
      // Random start point lets ready responses overtake each other
      valid_q = 1'b0;
      found   = 1'b0;
      start   = $urandom_range(LB_DEPTH - 1);
      for (int k = 0; k < LB_DEPTH; k++) begin
        t = lb_idx_t'(start + k);
        if (!found && pending[t] && delay[t] == 0) begin
          found      = 1'b1;
          pending[t] = 1'b0;
          valid_q    = 1'b1;
          tag_q      = t;
          rdata_q    = read_dword(addr[t]);
        end
      end
      // A request seen here is taken at the next rising edge
      ready_q = $urandom_range(3) != 0;
      if (req_valid_i && ready_q) begin
        pending[req_tag_i] = 1'b1;
        delay[req_tag_i]   = $urandom_range(8, 1);
        addr[req_tag_i]    = req_addr_i;
      end
    end
  end

  assign req_ready_o  = ready_q;
  assign resp_valid_o = valid_q;
  assign resp_tag_o   = tag_q;
  assign resp_rdata_o = rdata_q;

endmodule

`default_nettype wire

/* bench/tb_load_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_load_buffer;
  import lb_pkg::*;

  // Room for about 75 loads at up to 40 cycles each
  localparam int unsigned MAX_LOADS       = 75;
  localparam int unsigned MAX_LOAD_CYCLES = 40;
  localparam int unsigned TIMEOUT_CYCLES  = MAX_LOADS * MAX_LOAD_CYCLES;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      issue_valid;
  logic      issue_ready;
  ld_width_t issue_width;
  data_t     issue_base;
  data_t     issue_offs;
  rob_idx_t  issue_rob_idx;
  logic      cdb_valid;
  logic      cdb_ready;
  rob_idx_t  cdb_rob_idx;
  data_t     cdb_value;
  logic      mem_valid;
  logic      mem_ready;
  addr_t     mem_addr;
  lb_idx_t   mem_tag;
  logic      resp_valid;
  lb_idx_t   resp_tag;
  data_t     resp_rdata;

  // Loads waiting to issue, and results expected in issue order
  ld_width_t iss_width [$];
  data_t     iss_base  [$];
  data_t     iss_offs  [$];
  rob_idx_t  iss_rob   [$];
  data_t     exp_value [$];
  rob_idx_t  exp_rob   [$];

  rob_idx_t    next_rob;
  lb_idx_t     next_tag;
  logic        hold_cdb;
  int unsigned accepted;
  int unsigned errors;
  int unsigned checks;
  int unsigned cycle_cnt = 0;

  always #2 clk = ~clk;

  load_buffer load_buffer_i (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .issue_valid_i   (issue_valid),
    .issue_ready_o   (issue_ready),
    .issue_width_i   (issue_width),
    .issue_base_i    (issue_base),
    .issue_offs_i    (issue_offs),
    .issue_rob_idx_i (issue_rob_idx),
    .cdb_valid_o     (cdb_valid),
    .cdb_ready_i     (cdb_ready),
    .cdb_rob_idx_o   (cdb_rob_idx),
    .cdb_value_o     (cdb_value),
    .mem_valid_o     (mem_valid),
    .mem_ready_i     (mem_ready),
    .mem_addr_o      (mem_addr),
    .mem_tag_o       (mem_tag),
    .mem_valid_i     (resp_valid),
    .mem_tag_i       (resp_tag),
    .mem_rdata_i     (resp_rdata)
  );

  lb_mem_model u_mem (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_valid_i  (mem_valid),
    .req_ready_o  (mem_ready),
    .req_addr_i   (mem_addr),
    .req_tag_i    (mem_tag),
    .resp_valid_o (resp_valid),
    .resp_tag_o   (resp_tag),
    .resp_rdata_o (resp_rdata)
  );

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // Requests go out in issue order, each tagged with its entry index
  always @(posedge clk) begin
    if (rst_n && mem_valid && mem_ready) begin
      check_tag(mem_tag, next_tag, "request tag");
      next_tag = next_tag + lb_idx_t'(1);
    end
  end

  // ------------------------------
  // Reference model
  // ------------------------------

  function automatic int unsigned load_bytes(ld_width_t w);
    case (w)
      LD_B, LD_BU: return 1;
      LD_H, LD_HU: return 2;
      LD_W, LD_WU: return 4;
      default:     return 8;
    endcase
  endfunction

  function automatic logic [7:0] mem_byte(addr_t a);
    return a[7:0] ^ 8'h5a;
  endfunction

  // Gather the loaded bytes, then extend from the top one
  function automatic data_t expect_load(ld_width_t w, addr_t a);
    data_t       v;
    int unsigned n;
    logic        signed_load;
    v = '0;
    n = load_bytes(w);
    signed_load = (w == LD_B) || (w == LD_H) || (w == LD_W);
    for (int unsigned i = 0; i < n; i++) begin
      v[8*i +: 8] = mem_byte(a + addr_t'(i));
    end
    if (signed_load && v[8*n-1]) begin
      for (int unsigned b = 8*n; b < XLEN; b++) begin
        v[b] = 1'b1;
      end
    end
    return v;
  endfunction

  // ------------------------------
  // Checks and driving
  // ------------------------------

  task automatic check_value(input data_t got, input data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rob_idx(input rob_idx_t got, input rob_idx_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_tag(input lb_idx_t got, input lb_idx_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic queue_load(input ld_width_t w, input data_t base, input data_t offs);
    iss_width.push_back(w);
    iss_base.push_back(base);
    iss_offs.push_back(offs);
    iss_rob.push_back(next_rob);
    exp_value.push_back(expect_load(w, base + offs));
    exp_rob.push_back(next_rob);
    next_rob = next_rob + rob_idx_t'(7);
  endtask

  // Drive on the falling edge, then check what the next rising edge takes
  task automatic run_cycle();
    @(negedge clk);
    cdb_ready   = !hold_cdb;
    issue_valid = iss_width.size() != 0;
    if (issue_valid) begin
      issue_width   = iss_width[0];
      issue_base    = iss_base[0];
      issue_offs    = iss_offs[0];
      issue_rob_idx = iss_rob[0];
      if (issue_ready) begin
        void'(iss_width.pop_front());
        void'(iss_base.pop_front());
        void'(iss_offs.pop_front());
        void'(iss_rob.pop_front());
        accepted++;
      end
    end
    if (cdb_valid && cdb_ready) begin
      if (exp_value.size() == 0) begin
        errors++;
        $display("Result for rob index %0d came with no load outstanding", cdb_rob_idx);
      end else begin
        check_value(cdb_value, exp_value.pop_front(), "result value");
        check_rob_idx(cdb_rob_idx, exp_rob.pop_front(), "result rob index");
      end
    end
    if (mem_valid && mem_addr[2:0] != 3'b000) begin
      errors++;
      $display("FAIL %0t: request address %h is not doubleword aligned", $time, mem_addr);
    end
  endtask

  task automatic drain();
    while (iss_width.size() != 0 || exp_value.size() != 0) begin
      run_cycle();
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic test_reset();
    @(negedge clk);
    checks++;
    if (issue_ready !== 1'b1 || cdb_valid !== 1'b0 || mem_valid !== 1'b0) begin
      errors++;
      $display("FAIL %0t: after reset issue ready %b, cdb valid %b, mem valid %b",
               $time, issue_ready, cdb_valid, mem_valid);
    end
  endtask

  task automatic test_widths();
    for (int i = 0; i <= int'(LD_D); i++) begin
      queue_load(ld_width_t'(i), 64'h0000_0000_0000_1000, '0);
      // Negative offset onto bytes above 8'h7f
      queue_load(ld_width_t'(i), 64'h0000_0000_0000_2100, 64'hffff_ffff_ffff_ff80);
    end
    drain();
  endtask

  task automatic test_offsets();
    for (int o = 0; o < 8; o++) begin
      queue_load(LD_B, 64'h0000_0000_0001_00c0, data_t'(o));
      queue_load(LD_BU, 64'h0000_0000_0001_00c0, data_t'(o));
      if (o % 2 == 0) begin
        queue_load(LD_H, 64'h0000_0000_0001_00c0, data_t'(o));
        queue_load(LD_HU, 64'h0000_0000_0001_00c0, data_t'(o));
      end
      if (o % 4 == 0) begin
        queue_load(LD_W, 64'h0000_0000_0001_00c0, data_t'(o));
        queue_load(LD_WU, 64'h0000_0000_0001_00c0, data_t'(o));
      end
    end
    drain();
  endtask

  task automatic test_ordering();
    ld_width_t w;
    data_t     base;
    data_t     offs;
    for (int n = 0; n < 20; n++) begin
      w    = ld_width_t'($urandom_range(int'(LD_D)));
      base = {$urandom(), $urandom()} & ~data_t'(7);
      offs = data_t'($urandom_range(7)) & ~data_t'(load_bytes(w) - 1);
      queue_load(w, base, offs);
    end
    drain();
  endtask

  task automatic test_backpressure();
    hold_cdb = 1'b1;
    accepted = 0;
    for (int n = 0; n < 6; n++) begin
      queue_load(LD_W, 64'h0000_0000_0000_4440, data_t'(8 * n + 4 * (n % 2)));
    end
    // Four entries plus the stage register fill up
    repeat (MAX_LOAD_CYCLES) run_cycle();
    checks++;
    if (accepted != 5 || issue_ready !== 1'b0) begin
      errors++;
      $display("FAIL %0t: %0d loads taken with the result bus stalled, expected 5",
               $time, accepted);
    end
    hold_cdb = 1'b0;
    drain();
  endtask

  initial begin
    void'($urandom(32'h0a63_e7e2));
    rst_n         = 1'b0;
    issue_valid   = 1'b0;
    issue_width   = LD_B;
    issue_base    = '0;
    issue_offs    = '0;
    issue_rob_idx = '0;
    cdb_ready     = 1'b0;
    hold_cdb      = 1'b0;
    next_rob      = '0;
    next_tag      = '0;
    accepted      = 0;
    errors        = 0;
    checks        = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    test_reset();
    test_widths();
    test_offsets();
    test_ordering();
    test_backpressure();
    // Idle cycles catch a stray result
    repeat (20) run_cycle();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_load_buffer -f tb.f

out=$(./obj_dir/Vtb_load_buffer)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Everything OK'; then
  exit 0
else
  exit 1
fi

/* src/lb_entry_store.sv */
`timescale 1ns/1ps
`default_nettype none

module lb_entry_store (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Push from the issue stage
  input  logic               push_valid_i,
  output logic               push_ready_o,
  input  lb_pkg::ld_width_t  push_width_i,
  input  lb_pkg::addr_t      push_addr_i,
  input  lb_pkg::rob_idx_t   push_rob_idx_i,
  // Pop from writeback
  input  logic               pop_i,
  // Memory request
  output logic               mem_valid_o,
  input  logic               mem_ready_i,
  output lb_pkg::addr_t      mem_addr_o,
  output lb_pkg::lb_idx_t    mem_tag_o,
  // Memory response
  input  logic               mem_valid_i,
  input  lb_pkg::lb_idx_t    mem_tag_i,
  input  lb_pkg::data_t      mem_rdata_i,
  // Head entry
  output logic               head_valid_o,
  output lb_pkg::ld_width_t  head_width_o,
  output lb_pkg::byte_offs_t head_offs_o,
  output lb_pkg::data_t      head_data_o,
  output lb_pkg::rob_idx_t   head_rob_idx_o
);
  import lb_pkg::*;

  // ------------------------------
  // Entry array
  // ------------------------------

  ld_width_t width_q   [LB_DEPTH];
  addr_t     addr_q    [LB_DEPTH];
  rob_idx_t  rob_idx_q [LB_DEPTH];
  data_t     data_q    [LB_DEPTH];

  lb_state_t state_q   [LB_DEPTH];
  lb_state_t state_d   [LB_DEPTH];

  // Tail is next free slot, mem is next entry to request
  lb_idx_t tail_q;
  lb_idx_t head_q;
  lb_idx_t mem_q;

  logic push;
  logic mem_accept;

  assign push_ready_o = state_q[tail_q] == LB_S_EMPTY;
  assign push         = push_valid_i & push_ready_o;
  assign mem_accept   = mem_valid_o & mem_ready_i;

  // ------------------------------
  // Entry state machines
  // ------------------------------

  always_comb begin
    for (int i = 0; i < LB_DEPTH; i++) begin
      state_d[i] = state_q[i];
      case (state_q[i])
        LB_S_EMPTY: begin
          if (push && tail_q == lb_idx_t'(i)) begin
            state_d[i] = LB_S_MEM_REQ;
          end
        end
        LB_S_MEM_REQ: begin
          if (mem_accept && mem_q == lb_idx_t'(i)) begin
            state_d[i] = LB_S_MEM_WAIT;
          end
        end
        LB_S_MEM_WAIT: begin
          // Responses come back in any order
          if (mem_valid_i && mem_tag_i == lb_idx_t'(i)) begin
            state_d[i] = LB_S_DONE;
          end
        end
        LB_S_DONE: begin
          if (pop_i && head_q == lb_idx_t'(i)) begin
            state_d[i] = LB_S_EMPTY;
          end
        end
        default: state_d[i] = LB_S_EMPTY;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < LB_DEPTH; i++) begin
        state_q[i] <= LB_S_EMPTY;
      end
    end else begin
      state_q <= state_d;
    end
  end

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tail_q <= '0;
      head_q <= '0;
      mem_q  <= '0;
    end else begin
      if (push) begin
        tail_q <= tail_q + lb_idx_t'(1);
      end
      if (pop_i) begin
        head_q <= head_q + lb_idx_t'(1);
      end
      if (mem_accept) begin
        mem_q <= mem_q + lb_idx_t'(1);
      end
    end
  end

  // Payload written on push, data on response
  always_ff @(posedge clk_i) begin
    if (push) begin
      width_q[tail_q]   <= push_width_i;
      addr_q[tail_q]    <= push_addr_i;
      rob_idx_q[tail_q] <= push_rob_idx_i;
    end
    if (mem_valid_i) begin
      data_q[mem_tag_i] <= mem_rdata_i;
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------

  // Requests in program order, always a whole doubleword
  assign mem_valid_o = state_q[mem_q] == LB_S_MEM_REQ;
  assign mem_addr_o  = {addr_q[mem_q][XLEN-1:BYTE_OFFS_W], {BYTE_OFFS_W{1'b0}}};
  assign mem_tag_o   = mem_q;

  assign head_valid_o   = state_q[head_q] == LB_S_DONE;
  assign head_width_o   = width_q[head_q];
  assign head_offs_o    = addr_q[head_q][BYTE_OFFS_W-1:0];
  assign head_data_o    = data_q[head_q];
  assign head_rob_idx_o = rob_idx_q[head_q];

  // Memory must only answer requests it has accepted
  a_resp_tag_waiting : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid_i |-> state_q[mem_tag_i] == LB_S_MEM_WAIT)
    else $error("lb_entry_store: response tag %0d not waiting", mem_tag_i);

  // Writeback pops only a completed head
  a_pop_done : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> state_q[head_q] == LB_S_DONE)
    else $error("lb_entry_store: pop of entry %0d not done", head_q);

endmodule

`default_nettype wire

/* src/lb_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module lb_issue (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Issue port
  input  logic                issue_valid_i,
  output logic                issue_ready_o,
  input  lb_pkg::ld_width_t   issue_width_i,
  input  lb_pkg::data_t       issue_base_i,
  input  lb_pkg::data_t       issue_offs_i,
  input  lb_pkg::rob_idx_t    issue_rob_idx_i,
  // Push into the entry store
  output logic                push_valid_o,
  input  logic                push_ready_i,
  output lb_pkg::ld_width_t   push_width_o,
  output lb_pkg::addr_t       push_addr_o,
  output lb_pkg::rob_idx_t    push_rob_idx_o
);
  import lb_pkg::*;

  logic      stage_valid_q;
  ld_width_t stage_width_q;
  addr_t     stage_addr_q;
  rob_idx_t  stage_rob_idx_q;

  logic issue_fire;
  logic push_fire;
  logic addr_misaligned;

  assign push_fire     = stage_valid_q & push_ready_i;
  // Stage frees up in the same cycle it pushes
  assign issue_ready_o = ~stage_valid_q | push_fire;
  assign issue_fire    = issue_valid_i & issue_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_valid_q <= 1'b0;
    end else if (issue_fire) begin
      stage_valid_q <= 1'b1;
    end else if (push_fire) begin
      stage_valid_q <= 1'b0;
    end
  end

  // Effective address computed on entry
  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      stage_width_q   <= issue_width_i;
      stage_addr_q    <= issue_base_i + issue_offs_i;
      stage_rob_idx_q <= issue_rob_idx_i;
    end
  end

  assign push_valid_o   = stage_valid_q;
  assign push_width_o   = stage_width_q;
  assign push_addr_o    = stage_addr_q;
  assign push_rob_idx_o = stage_rob_idx_q;

  always_comb begin
    case (stage_width_q)
      LD_H, LD_HU: addr_misaligned = stage_addr_q[0];
      LD_W, LD_WU: addr_misaligned = |stage_addr_q[1:0];
      LD_D:        addr_misaligned = |stage_addr_q[2:0];
      default:     addr_misaligned = 1'b0;
    endcase
  end

  // Loads never cross a doubleword, the byte selector relies on it
  a_push_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_fire |-> !addr_misaligned)
    else $error("lb_issue: misaligned load pushed");

endmodule

`default_nettype wire

/* src/lb_pkg.sv */
`default_nettype none

package lb_pkg;

  // ------------------------------
  // Widths and sizes
  // ------------------------------

  // Data and address width
  localparam int unsigned XLEN = 64;

  // Entries in the circular buffer
  localparam int unsigned LB_DEPTH = 4;
  localparam int unsigned LB_IDX_W = $clog2(LB_DEPTH);

  // Reorder-buffer index width
  localparam int unsigned ROB_IDX_W = 5;

  // Byte position inside a doubleword
  localparam int unsigned BYTE_OFFS_W = $clog2(XLEN / 8);

  // ------------------------------
  // Types
  // ------------------------------

  typedef logic [XLEN-1:0]        data_t;
  typedef logic [XLEN-1:0]        addr_t;
  typedef logic [LB_IDX_W-1:0]    lb_idx_t;
  typedef logic [ROB_IDX_W-1:0]   rob_idx_t;
  typedef logic [BYTE_OFFS_W-1:0] byte_offs_t;

  // Load widths, U variants zero-extend
  typedef enum logic [2:0] {
    LD_B,
    LD_BU,
    LD_H,
    LD_HU,
    LD_W,
    LD_WU,
    LD_D
  } ld_width_t;

  // Per-entry state
  typedef enum logic [1:0] {
    LB_S_EMPTY,
    LB_S_MEM_REQ,
    LB_S_MEM_WAIT,
    LB_S_DONE
  } lb_state_t;

endpackage

`default_nettype wire

/* src/lb_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module lb_writeback (
  // Head entry from the store
  input  logic               head_valid_i,
  input  lb_pkg::ld_width_t  head_width_i,
  input  lb_pkg::byte_offs_t head_offs_i,
  input  lb_pkg::data_t      head_data_i,
  input  lb_pkg::rob_idx_t   head_rob_idx_i,
  output logic               pop_o,
  // Result bus
  output logic               cdb_valid_o,
  input  logic               cdb_ready_i,
  output lb_pkg::rob_idx_t   cdb_rob_idx_o,
  output lb_pkg::data_t      cdb_value_o
);
  import lb_pkg::*;

  data_t shifted;

  // ------------------------------
  // Byte selector
  // ------------------------------

  // Addressed byte moved down to bit 0
  assign shifted = head_data_i >> {head_offs_i, 3'b000};

  always_comb begin
    case (head_width_i)
      LD_B: begin
        cdb_value_o = {{(XLEN - 8){shifted[7]}}, shifted[7:0]};
      end
      LD_BU: begin
        cdb_value_o = {{(XLEN - 8){1'b0}}, shifted[7:0]};
      end
      LD_H: begin
        cdb_value_o = {{(XLEN - 16){shifted[15]}}, shifted[15:0]};
      end
      LD_HU: begin
        cdb_value_o = {{(XLEN - 16){1'b0}}, shifted[15:0]};
      end
      LD_W: begin
        cdb_value_o = {{(XLEN - 32){shifted[31]}}, shifted[31:0]};
      end
      LD_WU: begin
        cdb_value_o = {{(XLEN - 32){1'b0}}, shifted[31:0]};
      end
      // Full doubleword, offset is zero here
      default: begin
        cdb_value_o = shifted;
      end
    endcase
  end

  // ------------------------------
  // Result bus handshake
  // ------------------------------

  assign cdb_valid_o   = head_valid_i;
  assign cdb_rob_idx_o = head_rob_idx_i;
  assign pop_o         = head_valid_i & cdb_ready_i;

endmodule

`default_nettype wire

/* src/load_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module load_buffer (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Issue
  input  logic              issue_valid_i,
  output logic              issue_ready_o,
  input  lb_pkg::ld_width_t issue_width_i,
  input  lb_pkg::data_t     issue_base_i,
  input  lb_pkg::data_t     issue_offs_i,
  input  lb_pkg::rob_idx_t  issue_rob_idx_i,
  // Result bus
  output logic              cdb_valid_o,
  input  logic              cdb_ready_i,
  output lb_pkg::rob_idx_t  cdb_rob_idx_o,
  output lb_pkg::data_t     cdb_value_o,
  // Memory request
  output logic              mem_valid_o,
  input  logic              mem_ready_i,
  output lb_pkg::addr_t     mem_addr_o,
  output lb_pkg::lb_idx_t   mem_tag_o,
  // Memory response
  input  logic              mem_valid_i,
  input  lb_pkg::lb_idx_t   mem_tag_i,
  input  lb_pkg::data_t     mem_rdata_i
);
  import lb_pkg::*;

  // Issue stage to store
  logic      push_valid;
  logic      push_ready;
  ld_width_t push_width;
  addr_t     push_addr;
  rob_idx_t  push_rob_idx;

  // Store to writeback
  logic       head_valid;
  ld_width_t  head_width;
  byte_offs_t head_offs;
  data_t      head_data;
  rob_idx_t   head_rob_idx;
  logic       pop;

  lb_issue u_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_valid_i   (issue_valid_i),
    .issue_ready_o   (issue_ready_o),
    .issue_width_i   (issue_width_i),
    .issue_base_i    (issue_base_i),
    .issue_offs_i    (issue_offs_i),
    .issue_rob_idx_i (issue_rob_idx_i),
    .push_valid_o    (push_valid),
    .push_ready_i    (push_ready),
    .push_width_o    (push_width),
    .push_addr_o     (push_addr),
    .push_rob_idx_o  (push_rob_idx)
  );

  lb_entry_store u_entry_store (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_valid_i   (push_valid),
    .push_ready_o   (push_ready),
    .push_width_i   (push_width),
    .push_addr_i    (push_addr),
    .push_rob_idx_i (push_rob_idx),
    .pop_i          (pop),
    .mem_valid_o    (mem_valid_o),
    .mem_ready_i    (mem_ready_i),
    .mem_addr_o     (mem_addr_o),
    .mem_tag_o      (mem_tag_o),
    .mem_valid_i    (mem_valid_i),
    .mem_tag_i      (mem_tag_i),
    .mem_rdata_i    (mem_rdata_i),
    .head_valid_o   (head_valid),
    .head_width_o   (head_width),
    .head_offs_o    (head_offs),
    .head_data_o    (head_data),
    .head_rob_idx_o (head_rob_idx)
  );

  lb_writeback u_writeback (
    .head_valid_i   (head_valid),
    .head_width_i   (head_width),
    .head_offs_i    (head_offs),
    .head_data_i    (head_data),
    .head_rob_idx_i (head_rob_idx),
    .pop_o          (pop),
    .cdb_valid_o    (cdb_valid_o),
    .cdb_ready_i    (cdb_ready_i),
    .cdb_rob_idx_o  (cdb_rob_idx_o),
    .cdb_value_o    (cdb_value_o)
  );

endmodule

`default_nettype wire

/* tb.f */
src/lb_pkg.sv
src/lb_issue.sv
src/lb_entry_store.sv
src/lb_writeback.sv
src/load_buffer.sv
bench/lb_mem_model.sv
bench/tb_load_buffer.sv
